// ==== files.f ====
+incdir+source
source/csi_rx_pkg.sv
source/byte_aligner.sv
source/header_decoder.sv
source/line_engine.sv
source/pixel_writer.sv
source/csi_rx_top.sv
verification/tb_csi_rx.sv

// ==== source/byte_aligner.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "csi_rx_cfg.svh"

module byte_aligner import csi_rx_pkg::*; (
	input  logic       mipi_clk_2,
	input  logic       reset,
	input  logic       rx_active_i,
	input  nibble_t    lane0_nib_i,
	input  nibble_t    lane1_nib_i,
	output logic       byte_stb_o,
	output lane_byte_t byte0_o,
	output lane_byte_t byte1_o
);

	align_state_e state;
	logic         even_align;
	logic         phase;
	logic [5:0]   hist0;
	logic [5:0]   hist1;
	logic [9:0]   win0;
	logic [9:0]   win1;
	logic         hit_even;
	logic         hit_odd;
	lane_byte_t   sel0;
	lane_byte_t   sel1;

	// newest nibble on top, older bits below
	assign win0 = {lane0_nib_i, hist0};
	assign win1 = {lane1_nib_i, hist1};

	// even: byte ends at the newest bit, offset: two bits earlier
	assign hit_even = (win0[9:2] == `CSI_SYNC_BYTE);
	assign hit_odd  = (win0[7:0] == `CSI_SYNC_BYTE);

	assign sel0 = even_align ? win0[9:2] : win0[7:0];
	assign sel1 = even_align ? win1[9:2] : win1[7:0];

	////////////////////////////////////////////////////////////////////////////
	// sync hunt and byte phase
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge mipi_clk_2) begin
		if (reset || !rx_active_i) begin
			state      <= HUNT;
			even_align <= 1'b0;
			phase      <= 1'b0;
			byte_stb_o <= 1'b0;
			hist0      <= '0;
		end else begin
			hist0      <= win0[9:4];
			byte_stb_o <= 1'b0;
			case (state)
				HUNT: begin
					if (hit_even || hit_odd) begin
						state      <= LOCKED;
						even_align <= hit_even;
						phase      <= 1'b0;
					end
				end
				LOCKED: begin
					// a byte completes every second nibble
					phase      <= ~phase;
					byte_stb_o <= phase;
				end
				default: state <= HUNT;
			endcase
		end
	end

	always_ff @(posedge mipi_clk_2) begin
		hist1 <= win1[9:4];
		if (state == LOCKED && phase) begin
			byte0_o <= sel0;
			byte1_o <= sel1;
		end
	end

	a_stb_spaced: assert property (@(posedge mipi_clk_2) disable iff (reset)
		byte_stb_o |=> !byte_stb_o);

	a_stb_locked: assert property (@(posedge mipi_clk_2) disable iff (reset)
		byte_stb_o |-> (state == LOCKED));

endmodule

`default_nettype wire

// ==== source/csi_rx_cfg.svh ====
`ifndef CSI_RX_CFG_SVH
`define CSI_RX_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// protocol codes
////////////////////////////////////////////////////////////////////////////

// sync code on lane 0, bit 0 is the first bit on the wire
`define CSI_SYNC_BYTE 8'hB8

// packet data types
`define CSI_DT_RAW8        6'h2A
`define CSI_DT_FRAME_START 6'h00

////////////////////////////////////////////////////////////////////////////
// line geometry
////////////////////////////////////////////////////////////////////////////

// word count carried by a valid line header
`define CSI_LINE_BYTES 16'd640
// payload words per line, two lanes of two bytes
`define CSI_LINE_WORDS 8'd160

// crc-16 over the payload, reflected x^16+x^12+x^5+1
`define CSI_CRC_INIT 16'hFFFF
`define CSI_CRC_POLY 16'h8408

`endif

// ==== source/csi_rx_pkg.sv ====
`default_nettype none

package csi_rx_pkg;

	// lane side
	typedef logic [3:0] nibble_t;
	typedef logic [7:0] lane_byte_t;

	// assembled words and header fields
	typedef logic [31:0] csi_word_t;
	typedef logic [5:0]  data_type_t;
	typedef logic [15:0] word_count_t;
	typedef logic [5:0]  ecc_t;
	typedef logic [15:0] crc_t;

	// pixel output side
	typedef logic [31:0] pix_addr_t;
	typedef logic [15:0] coord_t;

	// sync search on lane 0
	typedef enum logic {HUNT, LOCKED} align_state_e;

	// first word of a burst is the header
	typedef enum logic [1:0] {WAIT_HEADER, PAYLOAD, DONE} hdr_state_e;

	// long packet handling
	typedef enum logic [1:0] {IDLE, RECEIVE, CHECK} line_state_e;

endpackage

`default_nettype wire

// ==== source/csi_rx_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module csi_rx_top import csi_rx_pkg::*; (
	input  logic      mipi_clk_2,
	input  logic      reset,
	input  logic      rx_active_i,
	input  nibble_t   lane0_nib_i,
	input  nibble_t   lane1_nib_i,
	output logic      pix_valid_o,
	output logic      line_done_o,
	output logic      crc_ok_o,
	output csi_word_t pix_data_o,
	output pix_addr_t pix_addr_o,
	output coord_t    pix_x_o,
	output coord_t    pix_y_o
);

	// decode stage
	logic        byte_stb;
	lane_byte_t  byte0;
	lane_byte_t  byte1;
	logic        hdr_stb;
	logic        word_stb;
	data_type_t  hdr_type;
	word_count_t hdr_count;
	csi_word_t   word;

	// execute stage
	logic        pix_stb;
	logic        line_start;
	logic        frame_start;
	csi_word_t   pix_word;

	byte_aligner u_byte_aligner (
		.mipi_clk_2 (mipi_clk_2),
		.reset      (reset),
		.rx_active_i(rx_active_i),
		.lane0_nib_i(lane0_nib_i),
		.lane1_nib_i(lane1_nib_i),
		.byte_stb_o (byte_stb),
		.byte0_o    (byte0),
		.byte1_o    (byte1)
	);

	header_decoder u_header_decoder (
		.mipi_clk_2 (mipi_clk_2),
		.reset      (reset),
		.rx_active_i(rx_active_i),
		.byte_stb_i (byte_stb),
		.byte0_i    (byte0),
		.byte1_i    (byte1),
		.hdr_stb_o  (hdr_stb),
		.word_stb_o (word_stb),
		.hdr_type_o (hdr_type),
		.hdr_count_o(hdr_count),
		.word_o     (word)
	);

	line_engine u_line_engine (
		.mipi_clk_2   (mipi_clk_2),
		.reset        (reset),
		.rx_active_i  (rx_active_i),
		.hdr_stb_i    (hdr_stb),
		.word_stb_i   (word_stb),
		.hdr_type_i   (hdr_type),
		.hdr_count_i  (hdr_count),
		.word_i       (word),
		.pix_stb_o    (pix_stb),
		.line_start_o (line_start),
		.frame_start_o(frame_start),
		.line_done_o  (line_done_o),
		.crc_ok_o     (crc_ok_o),
		.pix_word_o   (pix_word)
	);

	// result stage
	pixel_writer u_pixel_writer (
		.mipi_clk_2   (mipi_clk_2),
		.reset        (reset),
		.pix_stb_i    (pix_stb),
		.line_start_i (line_start),
		.frame_start_i(frame_start),
		.pix_word_i   (pix_word),
		.pix_valid_o  (pix_valid_o),
		.pix_data_o   (pix_data_o),
		.pix_addr_o   (pix_addr_o),
		.pix_x_o      (pix_x_o),
		.pix_y_o      (pix_y_o)
	);

endmodule

`default_nettype wire

// ==== source/header_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module header_decoder import csi_rx_pkg::*; (
	input  logic        mipi_clk_2,
	input  logic        reset,
	input  logic        rx_active_i,
	input  logic        byte_stb_i,
	input  lane_byte_t  byte0_i,
	input  lane_byte_t  byte1_i,
	output logic        hdr_stb_o,
	output logic        word_stb_o,
	output data_type_t  hdr_type_o,
	output word_count_t hdr_count_o,
	output csi_word_t   word_o
);

	hdr_state_e  state;
	logic        second;
	logic [15:0] lo_half;
	csi_word_t   asm_word;
	logic        hdr_ok;

	// csi-2 header ecc, one parity mask per ecc bit
	function automatic ecc_t ecc_calc(input logic [23:0] hdr);
		ecc_t ecc;
		ecc[0] = ^(hdr & 24'hF12CB7);
		ecc[1] = ^(hdr & 24'hF2555B);
		ecc[2] = ^(hdr & 24'h749A6D);
		ecc[3] = ^(hdr & 24'hB8E38E);
		ecc[4] = ^(hdr & 24'hDF03F0);
		ecc[5] = ^(hdr & 24'hEFFC00);
		return ecc;
	endfunction

	// second byte pair goes on top
	assign asm_word = {byte1_i, byte0_i, lo_half};

	// all-zero word would pass the ecc, so it is refused
	assign hdr_ok = (asm_word != '0) &&
		(asm_word[31:24] == {2'b00, ecc_calc(asm_word[23:0])});

	////////////////////////////////////////////////////////////////////////////
	// header / payload sequencing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge mipi_clk_2) begin
		if (reset || !rx_active_i) begin
			state      <= WAIT_HEADER;
			second     <= 1'b0;
			hdr_stb_o  <= 1'b0;
			word_stb_o <= 1'b0;
		end else begin
			hdr_stb_o  <= 1'b0;
			word_stb_o <= 1'b0;
			if (byte_stb_i) begin
				second <= ~second;
				if (second) begin
					case (state)
						WAIT_HEADER: begin
							if (hdr_ok) begin
								hdr_stb_o <= 1'b1;
								state     <= PAYLOAD;
							end else begin
								state <= DONE;
							end
						end
						PAYLOAD: word_stb_o <= 1'b1;
						// bad header, drop the rest of the burst
						default: state <= DONE;
					endcase
				end
			end
		end
	end

	always_ff @(posedge mipi_clk_2) begin
		if (byte_stb_i && !second) begin
			lo_half <= {byte1_i, byte0_i};
		end
		if (byte_stb_i && second) begin
			word_o <= asm_word;
			if (state == WAIT_HEADER) begin
				hdr_type_o  <= asm_word[5:0];
				hdr_count_o <= asm_word[23:8];
			end
		end
	end

	a_hdr_word_excl: assert property (@(posedge mipi_clk_2) disable iff (reset)
		!(hdr_stb_o && word_stb_o));

endmodule

`default_nettype wire

// ==== source/line_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "csi_rx_cfg.svh"

module line_engine import csi_rx_pkg::*; (
	input  logic        mipi_clk_2,
	input  logic        reset,
	input  logic        rx_active_i,
	input  logic        hdr_stb_i,
	input  logic        word_stb_i,
	input  data_type_t  hdr_type_i,
	input  word_count_t hdr_count_i,
	input  csi_word_t   word_i,
	output logic        pix_stb_o,
	output logic        line_start_o,
	output logic        frame_start_o,
	output logic        line_done_o,
	output logic        crc_ok_o,
	output csi_word_t   pix_word_o
);

	line_state_e state;
	logic [7:0]  word_cnt;
	crc_t        crc;
	logic        is_line_hdr;
	logic        is_frame_hdr;

	// reflected crc-16, bit 0 of each byte first
	function automatic crc_t crc_fold(input crc_t crc_in, input csi_word_t data);
		crc_t c;
		c = crc_in;
		for (int i = 0; i < 32; i++) begin
			if (c[0] ^ data[i]) begin
				c = (c >> 1) ^ `CSI_CRC_POLY;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

	assign is_line_hdr  = (hdr_type_i == `CSI_DT_RAW8) && (hdr_count_i == `CSI_LINE_BYTES);
	assign is_frame_hdr = (hdr_type_i == `CSI_DT_FRAME_START);

	////////////////////////////////////////////////////////////////////////////
	// packet dispatch and line reception
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge mipi_clk_2) begin
		if (reset || !rx_active_i) begin
			state         <= IDLE;
			word_cnt      <= '0;
			crc           <= `CSI_CRC_INIT;
			pix_stb_o     <= 1'b0;
			line_start_o  <= 1'b0;
			frame_start_o <= 1'b0;
			line_done_o   <= 1'b0;
		end else begin
			pix_stb_o     <= 1'b0;
			line_start_o  <= 1'b0;
			frame_start_o <= 1'b0;
			line_done_o   <= 1'b0;
			case (state)
				IDLE: begin
					if (hdr_stb_i && is_frame_hdr) begin
						frame_start_o <= 1'b1;
					end
					// other types and lengths are ignored
					if (hdr_stb_i && is_line_hdr) begin
						line_start_o <= 1'b1;
						crc          <= `CSI_CRC_INIT;
						word_cnt     <= '0;
						state        <= RECEIVE;
					end
				end
				RECEIVE: begin
					if (word_stb_i) begin
						pix_stb_o <= 1'b1;
						crc       <= crc_fold(crc, word_i);
						word_cnt  <= word_cnt + 8'd1;
						if (word_cnt == `CSI_LINE_WORDS - 8'd1) begin
							state <= CHECK;
						end
					end
				end
				CHECK: begin
					// word after the payload holds the checksum
					if (word_stb_i) begin
						line_done_o <= 1'b1;
						state       <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// crc result stays valid across bursts
	always_ff @(posedge mipi_clk_2) begin
		if (reset) begin
			crc_ok_o <= 1'b0;
		end else if (rx_active_i && state == CHECK && word_stb_i) begin
			crc_ok_o <= (word_i[15:0] == crc);
		end
	end

	always_ff @(posedge mipi_clk_2) begin
		if (state == RECEIVE && word_stb_i) begin
			pix_word_o <= word_i;
		end
	end

	a_pix_in_receive: assert property (@(posedge mipi_clk_2) disable iff (reset)
		pix_stb_o |-> $past(state == RECEIVE));

endmodule

`default_nettype wire

// ==== source/pixel_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module pixel_writer import csi_rx_pkg::*; (
	input  logic      mipi_clk_2,
	input  logic      reset,
	input  logic      pix_stb_i,
	input  logic      line_start_i,
	input  logic      frame_start_i,
	input  csi_word_t pix_word_i,
	output logic      pix_valid_o,
	output csi_word_t pix_data_o,
	output pix_addr_t pix_addr_o,
	output coord_t    pix_x_o,
	output coord_t    pix_y_o
);

	pix_addr_t addr;
	coord_t    x_pos;
	coord_t    line_num;
	logic      first_line;

	always_ff @(posedge mipi_clk_2) begin
		if (reset) begin
			addr        <= '0;
			x_pos       <= '0;
			line_num    <= '0;
			first_line  <= 1'b1;
			pix_valid_o <= 1'b0;
			pix_data_o  <= '0;
			pix_addr_o  <= '0;
			pix_x_o     <= '0;
			pix_y_o     <= '0;
		end else begin
			pix_valid_o <= pix_stb_i;
			if (frame_start_i) begin
				addr       <= '0;
				line_num   <= '0;
				first_line <= 1'b1;
			end
			// first line of a frame keeps line 0
			if (line_start_i) begin
				x_pos      <= '0;
				first_line <= 1'b0;
				if (!first_line) begin
					line_num <= line_num + 16'd1;
				end
			end
			// present current position, then step
			if (pix_stb_i) begin
				pix_data_o <= pix_word_i;
				pix_addr_o <= addr;
				pix_x_o    <= x_pos;
				pix_y_o    <= line_num;
				addr       <= addr + 32'd1;
				x_pos      <= x_pos + 16'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verification/tb_csi_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "csi_rx_cfg.svh"

module tb_csi_rx import csi_rx_pkg::*; ();

	// 6 bursts of about 700 cycles plus frame starts, with margin
	localparam int TIMEOUT_CYCLES   = 6000;
	localparam int DONE_WAIT_CYCLES = 40;

	logic      mipi_clk_2;
	logic      reset;
	logic      rx_active_i;
	nibble_t   lane0_nib_i;
	nibble_t   lane1_nib_i;
	logic      pix_valid_o;
	logic      line_done_o;
	logic      crc_ok_o;
	csi_word_t pix_data_o;
	pix_addr_t pix_addr_o;
	coord_t    pix_x_o;
	coord_t    pix_y_o;

	// captured and expected pixel outputs
	csi_word_t got_data[$];
	pix_addr_t got_addr[$];
	coord_t    got_x[$];
	coord_t    got_y[$];
	logic      got_crc_ok[$];
	csi_word_t exp_data[$];
	pix_addr_t exp_addr[$];
	coord_t    exp_x[$];
	coord_t    exp_y[$];

	// serial bit streams, first bit on the wire at the front
	logic      lane0_bits[$];
	logic      lane1_bits[$];
	csi_word_t tx_words[$];

	logic [31:0] rng_state;
	int          cycle_count = 0;
	int          error_count = 0;

	csi_rx_top u_dut (
		.mipi_clk_2 (mipi_clk_2),
		.reset      (reset),
		.rx_active_i(rx_active_i),
		.lane0_nib_i(lane0_nib_i),
		.lane1_nib_i(lane1_nib_i),
		.pix_valid_o(pix_valid_o),
		.line_done_o(line_done_o),
		.crc_ok_o   (crc_ok_o),
		.pix_data_o (pix_data_o),
		.pix_addr_o (pix_addr_o),
		.pix_x_o    (pix_x_o),
		.pix_y_o    (pix_y_o)
	);

	always #10 mipi_clk_2 = ~mipi_clk_2;

	always @(posedge mipi_clk_2) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	end

	// outputs are stable at the falling edge
	always @(negedge mipi_clk_2) begin
		if (!reset) begin
			if (pix_valid_o) begin
				got_data.push_back(pix_data_o);
				got_addr.push_back(pix_addr_o);
				got_x.push_back(pix_x_o);
				got_y.push_back(pix_y_o);
			end
			if (line_done_o) begin
				got_crc_ok.push_back(crc_ok_o);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// reference models
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// header parity equations, bit by bit
	function automatic ecc_t header_ecc(input logic [23:0] d);
		ecc_t e;
		e[0] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[13] ^
			d[16] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
		e[1] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[12] ^ d[14] ^
			d[17] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
		e[2] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[11] ^ d[12] ^ d[15] ^
			d[18] ^ d[20] ^ d[21] ^ d[22];
		e[3] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[13] ^ d[14] ^ d[15] ^
			d[19] ^ d[20] ^ d[21] ^ d[23];
		e[4] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[16] ^ d[17] ^ d[18] ^
			d[19] ^ d[20] ^ d[22] ^ d[23];
		e[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17] ^
			d[18] ^ d[19] ^ d[21] ^ d[22] ^ d[23];
		return e;
	endfunction

	// byte-wise crc-16, low byte of the word first
	function automatic crc_t crc16_bytes(input crc_t crc_in, input csi_word_t w);
		crc_t c;
		c = crc_in;
		for (int b = 0; b < 4; b++) begin
			c = c ^ {8'h00, w[8*b +: 8]};
			for (int k = 0; k < 8; k++) begin
				c = c[0] ? ((c >> 1) ^ `CSI_CRC_POLY) : (c >> 1);
			end
		end
		return c;
	endfunction

	function automatic csi_word_t make_header(input data_type_t dt, input word_count_t count);
		logic [23:0] h;
		h = {count, 2'b00, dt};
		return {2'b00, header_ecc(h), h};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus and checking
	////////////////////////////////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge mipi_clk_2);
		#2;
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			error_count++;
			$display("error: %s expected %0h actual %0h", what, expected, actual);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic push_byte(input bit lane, input lane_byte_t b);
		for (int i = 0; i < 8; i++) begin
			if (lane) begin
				lane1_bits.push_back(b[i]);
			end else begin
				lane0_bits.push_back(b[i]);
			end
		end
	endtask

	// lane 0 carries bytes 0 and 2, lane 1 bytes 1 and 3
	task automatic push_word(input csi_word_t w);
		push_byte(1'b0, w[7:0]);
		push_byte(1'b1, w[15:8]);
		push_byte(1'b0, w[23:16]);
		push_byte(1'b1, w[31:24]);
	endtask

	// offset puts the sync byte two bits into a nibble
	task automatic play_burst(input bit offset);
		nibble_t n0;
		nibble_t n1;
		int      pad;
		lane0_bits.delete();
		lane1_bits.delete();
		pad = offset ? 18 : 16;
		repeat (pad) begin
			lane0_bits.push_back(1'b0);
			lane1_bits.push_back(1'b0);
		end
		push_byte(1'b0, `CSI_SYNC_BYTE);
		push_byte(1'b1, `CSI_SYNC_BYTE);
		foreach (tx_words[i]) begin
			push_word(tx_words[i]);
		end
		while (lane0_bits.size() % 4 != 0) begin
			lane0_bits.push_back(1'b0);
			lane1_bits.push_back(1'b0);
		end
		rx_active_i = 1'b1;
		while (lane0_bits.size() > 0) begin
			for (int j = 0; j < 4; j++) begin
				n0[j] = lane0_bits.pop_front();
				n1[j] = lane1_bits.pop_front();
			end
			lane0_nib_i = n0;
			lane1_nib_i = n1;
			next_cycle();
		end
		lane0_nib_i = '0;
		lane1_nib_i = '0;
	endtask

	task automatic idle_cycles(input int n);
		lane0_nib_i = '0;
		lane1_nib_i = '0;
		repeat (n) next_cycle();
	endtask

	task automatic close_burst();
		rx_active_i = 1'b0;
		idle_cycles(4);
	endtask

	task automatic wait_line_done(input string name, input int target);
		int waited;
		waited = 0;
		while (got_crc_ok.size() < target && waited < DONE_WAIT_CYCLES) begin
			next_cycle();
			waited++;
		end
		if (got_crc_ok.size() < target) begin
			$display("test %s: line_done_o did not arrive after the burst", name);
			$display("Simulation failed");
			$fatal(1, "missing line_done_o");
		end
	endtask

	task automatic clear_queues();
		got_data.delete();
		got_addr.delete();
		got_x.delete();
		got_y.delete();
		got_crc_ok.delete();
		exp_data.delete();
		exp_addr.delete();
		exp_x.delete();
		exp_y.delete();
	endtask

	// header, random payload, then the checksum word
	task automatic build_line(input csi_word_t header, input int n_words, input bit bad_crc,
		input pix_addr_t base_addr, input coord_t line_y);
		crc_t      crc;
		csi_word_t w;
		tx_words.delete();
		tx_words.push_back(header);
		crc = `CSI_CRC_INIT;
		for (int i = 0; i < n_words; i++) begin
			rng_state = xorshift32(rng_state);
			w = rng_state;
			tx_words.push_back(w);
			crc = crc16_bytes(crc, w);
			exp_data.push_back(w);
			exp_addr.push_back(base_addr + pix_addr_t'(i));
			exp_x.push_back(coord_t'(i));
			exp_y.push_back(line_y);
		end
		if (bad_crc) begin
			crc = crc ^ 16'h0001;
		end
		tx_words.push_back({16'h0000, crc});
	endtask

	task automatic compare_outputs(input string name, input int n_done, input logic crc_ok);
		check_value({name, " word count"}, exp_data.size(), got_data.size());
		foreach (exp_data[i]) begin
			check_value($sformatf("%s data[%0d]", name, i), exp_data[i], got_data[i]);
			check_value($sformatf("%s addr[%0d]", name, i), exp_addr[i], got_addr[i]);
			check_value($sformatf("%s x[%0d]", name, i), exp_x[i], got_x[i]);
			check_value($sformatf("%s y[%0d]", name, i), exp_y[i], got_y[i]);
		end
		check_value({name, " line_done count"}, n_done, got_crc_ok.size());
		if (n_done > 0) begin
			check_value({name, " crc_ok"}, crc_ok, got_crc_ok[0]);
		end
		clear_queues();
	endtask

	// frame number must be nonzero, an all-zero header is refused
	task automatic send_frame_start(input word_count_t frame_num);
		tx_words.delete();
		tx_words.push_back(make_header(`CSI_DT_FRAME_START, frame_num));
		play_burst(1'b0);
		idle_cycles(10);
		close_burst();
	endtask

	task automatic send_line(input string name, input bit offset, input bit bad_crc,
		input pix_addr_t base_addr, input coord_t line_y, input logic crc_ok);
		build_line(make_header(`CSI_DT_RAW8, `CSI_LINE_BYTES), `CSI_LINE_WORDS, bad_crc,
			base_addr, line_y);
		play_burst(offset);
		wait_line_done(name, 1);
		idle_cycles(4);
		close_burst();
		compare_outputs(name, 1, crc_ok);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_idle_after_reset();
		rx_active_i = 1'b1;
		idle_cycles(20);
		check_value("idle pix_valid_o", 1'b0, pix_valid_o);
		check_value("idle line_done_o", 1'b0, line_done_o);
		check_value("idle crc_ok_o", 1'b0, crc_ok_o);
		check_value("idle pix_data_o", 32'h0, pix_data_o);
		check_value("idle pix_addr_o", 32'h0, pix_addr_o);
		check_value("idle pix_x_o", 16'h0, pix_x_o);
		check_value("idle pix_y_o", 16'h0, pix_y_o);
		close_burst();
		compare_outputs("idle", 0, 1'b0);
	endtask

	task automatic test_rejected_headers();
		// ecc bit 0 flipped
		build_line(make_header(`CSI_DT_RAW8, `CSI_LINE_BYTES) ^ 32'h0100_0000,
			`CSI_LINE_WORDS, 1'b0, '0, '0);
		play_burst(1'b0);
		idle_cycles(12);
		close_burst();
		// valid header, wrong line length
		build_line(make_header(`CSI_DT_RAW8, 16'd320), 80, 1'b0, '0, '0);
		play_burst(1'b1);
		idle_cycles(12);
		close_burst();
		exp_data.delete();
		exp_addr.delete();
		exp_x.delete();
		exp_y.delete();
		compare_outputs("rejected_headers", 0, 1'b0);
	endtask

	initial begin
		mipi_clk_2  = 1'b0;
		reset       = 1'b1;
		rx_active_i = 1'b0;
		lane0_nib_i = '0;
		lane1_nib_i = '0;
		rng_state   = 32'h34b33c69;
		repeat (3) @(posedge mipi_clk_2);
		#2;
		reset = 1'b0;
		next_cycle();

		test_idle_after_reset();
		send_frame_start(16'd1);
		send_line("even_line", 1'b0, 1'b0, 32'd0, 16'd0, 1'b1);
		send_line("offset_line", 1'b1, 1'b0, 32'd160, 16'd1, 1'b1);
		test_rejected_headers();
		send_line("bad_crc", 1'b0, 1'b1, 32'd320, 16'd2, 1'b0);
		send_frame_start(16'd2);
		send_line("new_frame", 1'b1, 1'b0, 32'd0, 16'd0, 1'b1);

		if (error_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
